// ==== axi_read_upsizer.f ====
verilog/axi_bus_pkg.sv
verilog/upsize_read_pkg.sv
verilog/ar_translate.sv
verilog/ar_info_fifo.sv
verilog/r_beat_splitter.sv
verilog/axi_read_upsizer.sv
dv/axi_read_upsizer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the read upsizer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
    --top-module axi_read_upsizer_tb -f axi_read_upsizer.f
./obj_dir/Vaxi_read_upsizer_tb | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== dv/axi_read_upsizer_patterns.txt ====
// Columns: request address, narrow length, id, user, expected wide length
// One read request per line, all values in hex
00001000 03 1 05 00
00001004 00 2 0a 00
00001008 05 3 11 01
0000200c 07 4 3f 02
00002000 0f 5 20 03
00003004 0a 6 01 02
00003108 01 7 2c 00
0000310c 01 0 13 01
00004000 1f 1 07 07
00004444 02 2 18 00
0000500c 00 3 3e 00
00005010 10 4 09 04
00006008 03 5 15 01
00007fe4 06 6 2a 01
00008000 00 7 00 00
0000900c 0d 0 31 04

// ==== dv/axi_read_upsizer_tb.sv ====
// Testbench for the AXI4 read upsizer
// Issues read requests from a pattern file, models the 128-bit
// memory slave with random gaps and checks every narrow beat

`timescale 1ns/10ps
`default_nettype none

module axi_read_upsizer_tb
    import axi_bus_pkg::*;
();

    localparam int NUM_PATTERNS   = 16;
    localparam int FIELDS         = 5;
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 2;
    // Master R held back at start so the request queue fills
    localparam int FIRST_R_DELAY  = 40;
    localparam int BURST_PATTERNS = 6;
    localparam int MAX_OUTSTAND   = 4;

    logic clk;
    logic rst_n;

    logic         s_ar_valid;
    addr_t        s_ar_addr;
    axi_len_t     s_ar_len;
    axi_id_t      s_ar_id;
    axi_user_t    s_ar_user;
    logic         s_ar_ready;
    logic         s_r_valid;
    narrow_data_t s_r_data;
    logic         s_r_last;
    axi_id_t      s_r_id;
    axi_user_t    s_r_user;
    logic         s_r_ready;
    logic         m_ar_valid;
    addr_t        m_ar_addr;
    axi_len_t     m_ar_len;
    axi_size_t    m_ar_size;
    axi_id_t      m_ar_id;
    axi_user_t    m_ar_user;
    logic         m_ar_ready;
    logic         m_r_valid;
    wide_data_t   m_r_data;
    logic         m_r_last;
    logic         m_r_ready;

    logic [31:0] pat_mem [NUM_PATTERNS*FIELDS];
    integer      seed;
    logic        r_slot;
    logic        ar_slot;

    // Wide reads accepted by the memory model, in order
    addr_t    rd_addr_q[$];
    axi_len_t rd_len_q[$];

    int ar_count        = 0;
    int done_count      = 0;
    int sb_beat         = 0;
    int max_outstanding = 0;
    int err_count       = 0;
    int pass_count      = 0;
    int fail_count      = 0;
    int test_err [NUM_PATTERNS];

    axi_read_upsizer DUT
    (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .s_ar_valid_i (s_ar_valid),
        .s_ar_addr_i  (s_ar_addr),
        .s_ar_len_i   (s_ar_len),
        .s_ar_id_i    (s_ar_id),
        .s_ar_user_i  (s_ar_user),
        .s_ar_ready_o (s_ar_ready),
        .s_r_valid_o  (s_r_valid),
        .s_r_data_o   (s_r_data),
        .s_r_last_o   (s_r_last),
        .s_r_id_o     (s_r_id),
        .s_r_user_o   (s_r_user),
        .s_r_ready_i  (s_r_ready),
        .m_ar_valid_o (m_ar_valid),
        .m_ar_addr_o  (m_ar_addr),
        .m_ar_len_o   (m_ar_len),
        .m_ar_size_o  (m_ar_size),
        .m_ar_id_o    (m_ar_id),
        .m_ar_user_o  (m_ar_user),
        .m_ar_ready_i (m_ar_ready),
        .m_r_valid_i  (m_r_valid),
        .m_r_data_i   (m_r_data),
        .m_r_last_i   (m_r_last),
        .m_r_ready_o  (m_r_ready)
    );

    //////////////////////////////////////////////////
    // Pattern fields and memory model
    //////////////////////////////////////////////////

    function automatic addr_t pat_addr(input int idx);
        return pat_mem[idx*FIELDS];
    endfunction

    function automatic axi_len_t pat_len(input int idx);
        return pat_mem[idx*FIELDS + 1][7:0];
    endfunction

    function automatic axi_id_t pat_id(input int idx);
        return pat_mem[idx*FIELDS + 2][2:0];
    endfunction

    function automatic axi_user_t pat_user(input int idx);
        return pat_mem[idx*FIELDS + 3][5:0];
    endfunction

    function automatic axi_len_t pat_wlen(input int idx);
        return pat_mem[idx*FIELDS + 4][7:0];
    endfunction

    // Word at a byte address is the address tagged A5 on top
    function automatic narrow_data_t mem_word(input addr_t addr);
        return {8'hA5, addr[23:0]};
    endfunction

    // Four consecutive words, lowest address in the low lane
    function automatic wide_data_t wide_beat(input addr_t addr);
        wide_data_t beat;
        for (int i = 0; i < 4; i++)
            beat[32*i +: 32] = mem_word(addr + addr_t'(4*i));
        return beat;
    endfunction

    task automatic report_error(input int idx, input string msg);
        $display("Fail %0t: test %0d %s", $time, idx, msg);
        err_count++;
        test_err[idx]++;
    endtask

    //////////////////////////////////////////////////
    // Stimulus processes
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // All random draws in one place, so the sequence is fixed
    task automatic draw_random();
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            s_r_ready  = ($random(seed) & 3) != 0;
            m_ar_ready = ($random(seed) & 3) != 0;
            r_slot     = ($random(seed) & 1) != 0;
            ar_slot    = ($random(seed) & 1) != 0;
        end
    endtask

    task automatic drive_requests();
        logic slot;
        for (int i = 0; i < NUM_PATTERNS; i++)
        begin
            s_ar_valid = 1'b1;
            s_ar_addr  = pat_addr(i);
            s_ar_len   = pat_len(i);
            s_ar_id    = pat_id(i);
            s_ar_user  = pat_user(i);
            @(posedge clk);
            while (!s_ar_ready)
                @(posedge clk);
            slot = ar_slot;
            #DRIVE_DELAY;
            s_ar_valid = 1'b0;
            // Opening requests back to back, later ones with idle gaps
            if (i >= BURST_PATTERNS - 1)
            begin
                while (!slot)
                begin
                    @(posedge clk);
                    slot = ar_slot;
                    #DRIVE_DELAY;
                end
            end
        end
    endtask

    // Memory slave, one wide burst per accepted master AR
    task automatic serve_reads();
        addr_t beat_addr;
        int    beats;
        logic  slot;
        repeat (FIRST_R_DELAY) @(posedge clk);
        forever
        begin
            @(posedge clk);
            slot = r_slot;
            #DRIVE_DELAY;
            if (slot && rd_addr_q.size() != 0)
            begin
                beat_addr = rd_addr_q.pop_front();
                beats     = int'(rd_len_q.pop_front()) + 1;
                for (int b = 0; b < beats; b++)
                begin
                    m_r_valid = 1'b1;
                    m_r_data  = wide_beat(beat_addr);
                    m_r_last  = (b == beats - 1);
                    @(posedge clk);
                    while (!m_r_ready)
                        @(posedge clk);
                    slot = r_slot;
                    #DRIVE_DELAY;
                    m_r_valid = 1'b0;
                    m_r_last  = 1'b0;
                    beat_addr = beat_addr + addr_t'(WIDE_BYTES);
                    while (!slot)
                    begin
                        @(posedge clk);
                        slot = r_slot;
                        #DRIVE_DELAY;
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Monitors and scoreboard
    //////////////////////////////////////////////////

    task automatic check_ar();
        int idx;
        idx = ar_count;
        if (idx >= NUM_PATTERNS)
        begin
            $display("Fail %0t: master read request with no pattern left", $time);
            err_count++;
        end
        else
        begin
            if (!(s_ar_valid && s_ar_ready))
                report_error(idx, "master AR taken without slave AR transfer");
            if (m_ar_addr != (pat_addr(idx) & 32'hFFFF_FFF0))
                report_error(idx, $sformatf("master address %h", m_ar_addr));
            if (m_ar_len != pat_wlen(idx))
                report_error(idx, $sformatf("master length %0d, expected %0d",
                                            m_ar_len, pat_wlen(idx)));
            if (m_ar_size != 3'd4)
                report_error(idx, $sformatf("master size %0d", m_ar_size));
            if (m_ar_id != pat_id(idx) || m_ar_user != pat_user(idx))
                report_error(idx, $sformatf("master id %0d user %h", m_ar_id, m_ar_user));
            rd_addr_q.push_back(m_ar_addr);
            rd_len_q.push_back(m_ar_len);
        end
        ar_count++;
    endtask

    task automatic check_r();
        int    idx;
        addr_t exp_addr;
        logic  exp_last;
        idx = done_count;
        if (idx >= NUM_PATTERNS)
        begin
            $display("Fail %0t: narrow read beat with no request open", $time);
            err_count++;
        end
        else
        begin
            exp_addr = pat_addr(idx) + addr_t'(4 * sb_beat);
            exp_last = (sb_beat == int'(pat_len(idx)));
            if (s_r_data != mem_word(exp_addr))
                report_error(idx, $sformatf("beat %0d data %h, expected %h",
                                            sb_beat, s_r_data, mem_word(exp_addr)));
            if (s_r_last != exp_last)
                report_error(idx, $sformatf("beat %0d last %b", sb_beat, s_r_last));
            if (s_r_id != pat_id(idx) || s_r_user != pat_user(idx))
                report_error(idx, $sformatf("beat %0d id %0d user %h",
                                            sb_beat, s_r_id, s_r_user));
            // Wide beat released only with lane 3 or the closing beat
            if (m_r_ready != (exp_addr[3:2] == 2'd3 || exp_last))
                report_error(idx, $sformatf("beat %0d master ready %b", sb_beat, m_r_ready));
            if (exp_last)
            begin
                if (test_err[idx] == 0)
                    $display("Test %0d: addr %h len %0d passed", idx, pat_addr(idx), pat_len(idx));
                else
                    $display("Test %0d: addr %h len %0d failed with %0d errors",
                             idx, pat_addr(idx), pat_len(idx), test_err[idx]);
                done_count++;
                sb_beat = 0;
            end
            else
                sb_beat++;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (m_ar_valid && m_ar_ready)
                check_ar();
            if (m_r_valid && m_r_ready && !(s_r_valid && s_r_ready))
            begin
                $display("Fail %0t: wide beat consumed with no narrow beat sent", $time);
                err_count++;
            end
            if (s_r_valid && s_r_ready)
                check_r();
            if (ar_count - done_count > MAX_OUTSTAND)
            begin
                $display("Fail %0t: %0d reads outstanding, limit is 4",
                         $time, ar_count - done_count);
                err_count++;
            end
            if (ar_count - done_count > max_outstanding)
                max_outstanding = ar_count - done_count;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        seed       = 32'h841f239f;
        rst_n      = 1'b0;
        s_ar_valid = 1'b0;
        s_ar_addr  = '0;
        s_ar_len   = '0;
        s_ar_id    = '0;
        s_ar_user  = '0;
        s_r_ready  = 1'b0;
        m_ar_ready = 1'b0;
        m_r_valid  = 1'b0;
        m_r_data   = '0;
        m_r_last   = 1'b0;
        r_slot     = 1'b0;
        ar_slot    = 1'b0;
        for (int i = 0; i < NUM_PATTERNS; i++)
            test_err[i] = 0;
        $readmemh("dv/axi_read_upsizer_patterns.txt", pat_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        fork
            draw_random();
            drive_requests();
            serve_reads();
        join_none

        wait (done_count == NUM_PATTERNS);
        repeat (5) @(posedge clk);

        if (max_outstanding != MAX_OUTSTAND)
        begin
            $display("Request queue never filled while read data was held back");
            err_count++;
        end
        for (int i = 0; i < NUM_PATTERNS; i++)
        begin
            if (test_err[i] == 0)
                pass_count++;
            else
                fail_count++;
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, err_count);
        if (err_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // 2000 cycles per pattern
    initial
    begin
        repeat (RESET_CYCLES + NUM_PATTERNS * 2000) @(posedge clk);
        $display("Timeout with %0d of %0d requests completed", done_count, NUM_PATTERNS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/axi_read_upsizer.sv ====
// AXI4 read upsizer, 32-bit slave side to 128-bit master side.
// Read requests pass straight through with a wide address and
// length. A small queue remembers each request so the returned
// wide beats can be split back into narrow INCR beats

`timescale 1ns/10ps
`default_nettype none

module axi_read_upsizer
    import axi_bus_pkg::*;
    import upsize_read_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Slave AR
    input  logic         s_ar_valid_i,
    input  addr_t        s_ar_addr_i,
    input  axi_len_t     s_ar_len_i,
    input  axi_id_t      s_ar_id_i,
    input  axi_user_t    s_ar_user_i,
    output logic         s_ar_ready_o,

    // Slave R
    output logic         s_r_valid_o,
    output narrow_data_t s_r_data_o,
    output logic         s_r_last_o,
    output axi_id_t      s_r_id_o,
    output axi_user_t    s_r_user_o,
    input  logic         s_r_ready_i,

    // Master AR
    output logic         m_ar_valid_o,
    output addr_t        m_ar_addr_o,
    output axi_len_t     m_ar_len_o,
    output axi_size_t    m_ar_size_o,
    output axi_id_t      m_ar_id_o,
    output axi_user_t    m_ar_user_o,
    input  logic         m_ar_ready_i,

    // Master R
    input  logic         m_r_valid_i,
    input  wide_data_t   m_r_data_i,
    input  logic         m_r_last_i,
    output logic         m_r_ready_o
);

    lane_t    first_lane;
    lane_t    last_lane;
    logic     info_full;
    logic     ar_push;
    logic     info_valid;
    logic     info_pop;
    axi_len_t info_len;
    lane_t    info_first_lane;

    //////////////////////////////////////////////////
    // Request path
    //////////////////////////////////////////////////

    ar_translate u_ar_translate
    (
        .slave_addr_i (s_ar_addr_i),
        .slave_len_i  (s_ar_len_i),
        .wide_addr_o  (m_ar_addr_o),
        .wide_len_o   (m_ar_len_o),
        .first_lane_o (first_lane),
        .last_lane_o  (last_lane)
    );

    assign m_ar_size_o = WIDE_SIZE;
    assign m_ar_id_o   = s_ar_id_i;
    assign m_ar_user_o = s_ar_user_i;

    // Both AR sides stall while the queue has no room
    assign m_ar_valid_o = s_ar_valid_i & ~info_full;
    assign s_ar_ready_o = m_ar_ready_i & ~info_full;

    // Master transfer and slave transfer coincide
    assign ar_push = m_ar_valid_o & m_ar_ready_i;

    //////////////////////////////////////////////////
    // Request info queue
    //////////////////////////////////////////////////

    // Head last lane kept for the record, the splitter counts beats
    ar_info_fifo u_ar_info_fifo
    (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (ar_push),
        .slave_len_i  (s_ar_len_i),
        .id_i         (s_ar_id_i),
        .user_i       (s_ar_user_i),
        .first_lane_i (first_lane),
        .last_lane_i  (last_lane),
        .full_o       (info_full),
        .info_valid_o (info_valid),
        .pop_i        (info_pop),
        .slave_len_o  (info_len),
        .id_o         (s_r_id_o),
        .user_o       (s_r_user_o),
        .first_lane_o (info_first_lane),
        .last_lane_o  ()
    );

    //////////////////////////////////////////////////
    // Return path
    //////////////////////////////////////////////////

    // m_r_last_i not needed, narrow beats are counted in the splitter
    r_beat_splitter u_r_beat_splitter
    (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .info_valid_i (info_valid),
        .info_len_i   (info_len),
        .first_lane_i (info_first_lane),
        .pop_o        (info_pop),
        .m_r_valid_i  (m_r_valid_i),
        .m_r_data_i   (m_r_data_i),
        .m_r_ready_o  (m_r_ready_o),
        .s_r_valid_o  (s_r_valid_o),
        .s_r_data_o   (s_r_data_o),
        .s_r_last_o   (s_r_last_o),
        .s_r_ready_i  (s_r_ready_i)
    );

endmodule

`default_nettype wire

// ==== verilog/r_beat_splitter.sv ====
// Read data splitter
// Cuts each 128-bit master read beat into 32-bit slave beats.
// Starts at the first lane of the head request and counts the
// narrow beats down, so the final lane follows from the length.
// The wide beat is released after lane 3 or the closing beat

`timescale 1ns/10ps
`default_nettype none

module r_beat_splitter
    import axi_bus_pkg::*;
    import upsize_read_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Head of the request queue
    input  logic         info_valid_i,
    input  axi_len_t     info_len_i,
    input  lane_t        first_lane_i,
    output logic         pop_o,

    // Master R channel
    input  logic         m_r_valid_i,
    input  wide_data_t   m_r_data_i,
    output logic         m_r_ready_o,

    // Slave R channel
    output logic         s_r_valid_o,
    output narrow_data_t s_r_data_o,
    output logic         s_r_last_o,
    input  logic         s_r_ready_i
);

    //////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////

    split_state_e state_q;
    split_state_e state_d;

    // Lane sent on the next narrow beat
    lane_t        lane_q;
    lane_t        lane_d;

    // Narrow beats still owed after the current one
    axi_len_t     remain_q;
    axi_len_t     remain_d;

    // Wide beat viewed as its narrow words, lane 0 lowest
    narrow_data_t [RATIO-1:0] wide_words;

    // Narrow beat accepted by the slave this cycle
    logic         beat_fire;

    // Current beat closes the request
    logic         last_beat;

    // Current lane is the top word of the wide beat
    logic         top_lane;

    assign wide_words = m_r_data_i;

    assign last_beat  = (remain_q == '0);
    assign top_lane   = (lane_q == lane_t'(RATIO - 1));

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q  <= SPLIT_IDLE;
            lane_q   <= '0;
            remain_q <= '0;
        end
        else
        begin
            state_q  <= state_d;
            lane_q   <= lane_d;
            remain_q <= remain_d;
        end
    end

    //////////////////////////////////////////////////
    // Lane walk and handshakes
    //////////////////////////////////////////////////

    always_comb
    begin
        state_d     = state_q;
        lane_d      = lane_q;
        remain_d    = remain_q;

        s_r_valid_o = 1'b0;
        s_r_last_o  = 1'b0;
        m_r_ready_o = 1'b0;
        pop_o       = 1'b0;
        beat_fire   = 1'b0;

        // Data follows the lane in every state
        s_r_data_o  = wide_words[lane_q];

        case (state_q)
            SPLIT_IDLE:
            begin
                // Load the next request from the queue head
                if (info_valid_i)
                begin
                    lane_d   = first_lane_i;
                    remain_d = info_len_i;
                    state_d  = SPLIT_ACTIVE;
                end
            end

            SPLIT_ACTIVE:
            begin
                s_r_valid_o = m_r_valid_i;
                s_r_last_o  = last_beat;
                beat_fire   = m_r_valid_i & s_r_ready_i;

                // Only take the wide beat once its lanes are used up
                m_r_ready_o = beat_fire & (top_lane | last_beat);

                if (beat_fire)
                begin
                    // Lane wraps to 0 after lane 3
                    lane_d   = lane_q + 1'b1;
                    remain_d = remain_q - 1'b1;

                    if (last_beat)
                    begin
                        pop_o   = 1'b1;
                        state_d = SPLIT_IDLE;
                    end
                end
            end

            default:
            begin
                state_d = SPLIT_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ar_info_fifo.sv ====
// Read request information queue
// Circular buffer holding, per outstanding read, the narrow
// length, id, user and first and last word lanes. The head
// entry feeds the return path until it is popped

`timescale 1ns/10ps
`default_nettype none

module ar_info_fifo
    import axi_bus_pkg::*;
    import upsize_read_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Write side
    input  logic      push_i,
    input  axi_len_t  slave_len_i,
    input  axi_id_t   id_i,
    input  axi_user_t user_i,
    input  lane_t     first_lane_i,
    input  lane_t     last_lane_i,
    output logic      full_o,

    // Read side
    output logic      info_valid_o,
    input  logic      pop_i,
    output axi_len_t  slave_len_o,
    output axi_id_t   id_o,
    output axi_user_t user_o,
    output lane_t     first_lane_o,
    output lane_t     last_lane_o
);

    // Storage, one array per field
    axi_len_t  len_mem   [INFO_DEPTH];
    axi_id_t   id_mem    [INFO_DEPTH];
    axi_user_t user_mem  [INFO_DEPTH];
    lane_t     first_mem [INFO_DEPTH];
    lane_t     last_mem  [INFO_DEPTH];

    // Pointers wrap on their own since depth is a power of two
    logic [$clog2(INFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(INFO_DEPTH)-1:0] rd_ptr_q;

    // One extra bit so a full queue can be told from an empty one
    logic [$clog2(INFO_DEPTH):0]   count_q;

    logic do_push;
    logic do_pop;

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////

    // MSB alone is set only at INFO_DEPTH entries
    assign full_o       = count_q[$clog2(INFO_DEPTH)];
    assign info_valid_o = |count_q;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & info_valid_o;

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry write
    always_ff @(posedge clk_i)
    begin
        if (do_push)
        begin
            len_mem[wr_ptr_q]   <= slave_len_i;
            id_mem[wr_ptr_q]    <= id_i;
            user_mem[wr_ptr_q]  <= user_i;
            first_mem[wr_ptr_q] <= first_lane_i;
            last_mem[wr_ptr_q]  <= last_lane_i;
        end
    end

    // Head of queue
    assign slave_len_o  = len_mem[rd_ptr_q];
    assign id_o         = id_mem[rd_ptr_q];
    assign user_o       = user_mem[rd_ptr_q];
    assign first_lane_o = first_mem[rd_ptr_q];
    assign last_lane_o  = last_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== verilog/ar_translate.sv ====
// Read address translation
// Turns a narrow INCR read request into the matching wide one.
// Aligns the address to a wide beat, recomputes the beat count
// and reports the word lanes of the first and last narrow beat

`timescale 1ns/10ps
`default_nettype none

module ar_translate
    import axi_bus_pkg::*;
    import upsize_read_pkg::*;
(
    input  addr_t    slave_addr_i,
    input  axi_len_t slave_len_i,

    output addr_t    wide_addr_o,
    output axi_len_t wide_len_o,
    output lane_t    first_lane_o,
    output lane_t    last_lane_o
);

    //////////////////////////////////////////////////
    // Internal signals
    //////////////////////////////////////////////////

    // Byte address of the final narrow word
    addr_t end_addr;

    // End address rounded down to a wide beat
    addr_t end_wide_addr;

    // Byte distance between first and last wide beat
    addr_t wide_span;

    //////////////////////////////////////////////////
    // Address arithmetic
    //////////////////////////////////////////////////

    // Slave size is fixed so each beat moves NARROW_BYTES
    assign end_addr = slave_addr_i
                    + (addr_t'(slave_len_i) << $clog2(NARROW_BYTES));

    // Wide read starts on the beat holding the first word
    assign wide_addr_o   = slave_addr_i & ~addr_t'(WIDE_BYTES - 1);
    assign end_wide_addr = end_addr & ~addr_t'(WIDE_BYTES - 1);

    // Whole wide beats between the two ends
    assign wide_span  = end_wide_addr - wide_addr_o;
    assign wide_len_o = axi_len_t'(wide_span >> $clog2(WIDE_BYTES));

    //////////////////////////////////////////////////
    // Word lanes
    //////////////////////////////////////////////////

    // Word index inside the beat is address bits 3:2
    assign first_lane_o = slave_addr_i[$clog2(NARROW_BYTES) +: LANE_BITS];

    // Same bits of the end address give the closing lane
    assign last_lane_o  = end_addr[$clog2(NARROW_BYTES) +: LANE_BITS];

endmodule

`default_nettype wire

// ==== verilog/upsize_read_pkg.sv ====
// Read upsizer constants
// Word lane indexing inside a wide beat, depth of the
// request information queue and the splitter FSM states

`default_nettype none

package upsize_read_pkg;

    //////////////////////////////////////////////////
    // Converter geometry
    //////////////////////////////////////////////////

    // Narrow words per wide beat
    localparam int unsigned RATIO      = 4;

    // Bits needed to pick one of the RATIO words
    localparam int unsigned LANE_BITS  = 2;

    // Outstanding read requests
    localparam int unsigned INFO_DEPTH = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Word position inside a wide beat
    typedef logic [LANE_BITS-1:0] lane_t;

    // Return path FSM
    // Idle waits for request info, active walks lanes
    typedef enum logic
    {
        SPLIT_IDLE   = 1'b0,
        SPLIT_ACTIVE = 1'b1
    } split_state_e;

endpackage

`default_nettype wire

// ==== verilog/axi_bus_pkg.sv ====
// AXI bus definitions for the read upsizer
// Widths and field types shared by the 32-bit slave side
// and the 128-bit master side of the converter

`default_nettype none

package axi_bus_pkg;

    //////////////////////////////////////////////////
    // Field types
    //////////////////////////////////////////////////

    // Byte address on both sides
    typedef logic [31:0]  addr_t;

    // One slave-side word
    typedef logic [31:0]  narrow_data_t;

    // One master-side beat, four slave words
    typedef logic [127:0] wide_data_t;

    // Beats minus one, as on the AXI len field
    typedef logic [7:0]   axi_len_t;

    // Log2 of bytes per beat
    typedef logic [2:0]   axi_size_t;

    // Same id and user width on both sides
    typedef logic [2:0]   axi_id_t;
    typedef logic [5:0]   axi_user_t;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////

    localparam int unsigned NARROW_BYTES = 4;
    localparam int unsigned WIDE_BYTES   = 16;

    // Size code sent with every master read
    localparam axi_size_t   WIDE_SIZE    = 3'd4;

endpackage

`default_nettype wire
